/* logic/soc_periph_consts.svh */
`ifndef SOC_PERIPH_CONSTS_SVH
`define SOC_PERIPH_CONSTS_SVH

// bus and vector widths
`define SP_APB_AW           32
`define SP_APB_DW           32
`define SP_GPIO_W           32
`define SP_EVT_NUM          16
`define SP_EVT_W            8
`define SP_EVT_FIFO_DEPTH   4

// slave index taken from paddr[15:12]
`define SP_SLV_GPIO         4'd0
`define SP_SLV_EVT          4'd1

// gpio register offsets
`define SP_GPIO_DIR         12'h000
`define SP_GPIO_IN          12'h004
`define SP_GPIO_OUT         12'h008
`define SP_GPIO_INTEN       12'h00C
`define SP_GPIO_INTSTAT     12'h010

// event unit register offsets
`define SP_EVT_MASK         12'h000
`define SP_EVT_SW           12'h004
`define SP_EVT_ERR          12'h008

// event ids, sw events occupy 8..15
`define SP_EVT_ID_GPIO      0
`define SP_EVT_ID_REF_RISE  1
`define SP_EVT_ID_REF_FALL  2
`define SP_EVT_ID_SW0       8

// fc_events_o bit positions
`define SP_FC_BIT_REF       14
`define SP_FC_BIT_GPIO      15
`define SP_FC_BIT_ERR       29

`endif

/* logic/soc_periph_pkg.sv */
`default_nettype none

`include "soc_periph_consts.svh"

package soc_periph_pkg;

    typedef logic [`SP_APB_AW-1:0]  apb_addr_t;
    typedef logic [`SP_APB_DW-1:0]  apb_data_t;

    typedef logic [`SP_GPIO_W-1:0]  gpio_vec_t;   // one bit per pin

    typedef logic [`SP_EVT_NUM-1:0] evt_vec_t;    // one bit per event line
    typedef logic [`SP_EVT_W-1:0]   evt_id_t;     // id sent to the fc

endpackage

`default_nettype wire

/* logic/periph_apb_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_periph_consts.svh"

module periph_apb_decode (
    input  soc_periph_pkg::apb_addr_t paddr_i,
    input  logic                      psel_i,

    output logic                      gpio_psel_o,
    output logic                      evt_psel_o,

    input  soc_periph_pkg::apb_data_t gpio_prdata_i,
    input  logic                      gpio_pslverr_i,
    input  soc_periph_pkg::apb_data_t evt_prdata_i,
    input  logic                      evt_pslverr_i,

    output soc_periph_pkg::apb_data_t prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o
);

    logic [3:0] slv_idx;
    logic       hit_gpio;
    logic       hit_evt;

    assign slv_idx  = paddr_i[15:12];              // 4 kB per slave
    assign hit_gpio = (slv_idx == `SP_SLV_GPIO);
    assign hit_evt  = (slv_idx == `SP_SLV_EVT);

    assign gpio_psel_o = psel_i & hit_gpio;
    assign evt_psel_o  = psel_i & hit_evt;

    // every slave finishes in one access cycle
    assign pready_o = 1'b1;

    ////////////////////////////////////////////////////////////
    // read data and error return
    ////////////////////////////////////////////////////////////
    always_comb begin
        prdata_o  = '0;
        pslverr_o = 1'b0;
        if (hit_gpio) begin
            prdata_o  = gpio_prdata_i;
            pslverr_o = gpio_pslverr_i;
        end else if (hit_evt) begin
            prdata_o  = evt_prdata_i;
            pslverr_o = evt_pslverr_i;
        end else begin
            pslverr_o = psel_i;                   // nothing mapped here
        end
    end

endmodule

`default_nettype wire

/* logic/apb_gpio.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_periph_consts.svh"

module apb_gpio (
    input  logic                      clk_i,
    input  logic                      arst_n_i,

    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  soc_periph_pkg::apb_addr_t paddr_i,
    input  soc_periph_pkg::apb_data_t pwdata_i,
    output soc_periph_pkg::apb_data_t prdata_o,
    output logic                      pslverr_o,

    input  soc_periph_pkg::gpio_vec_t gpio_in_i,
    output soc_periph_pkg::gpio_vec_t gpio_out_o,
    output soc_periph_pkg::gpio_vec_t gpio_dir_o,
    output logic                      gpio_irq_o
);

    import soc_periph_pkg::*;

    gpio_vec_t   dir_q;
    gpio_vec_t   out_q;
    gpio_vec_t   inten_q;
    gpio_vec_t   intstat_q;
    gpio_vec_t   sync1_q;
    gpio_vec_t   sync2_q;
    gpio_vec_t   prev_q;
    gpio_vec_t   rise;
    logic        irq_q;
    logic [11:0] offs;
    logic        wr_en;
    logic        rd_stat;

    assign offs    = paddr_i[11:0];
    assign wr_en   = psel_i & penable_i & pwrite_i;
    assign rd_stat = psel_i & penable_i & ~pwrite_i & (offs == `SP_GPIO_INTSTAT);

    ////////////////////////////////////////////////////////////
    // input synchronizer and edge detect
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
            prev_q  <= '0;
        end else begin
            sync1_q <= gpio_in_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;                    // edge reference
        end
    end

    assign rise = sync2_q & ~prev_q & inten_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dir_q     <= '0;
            out_q     <= '0;
            inten_q   <= '0;
            intstat_q <= '0;
            irq_q     <= 1'b0;
        end else begin
            if (wr_en && offs == `SP_GPIO_DIR) begin
                dir_q <= pwdata_i;
            end
            if (wr_en && offs == `SP_GPIO_OUT) begin
                out_q <= pwdata_i;
            end
            if (wr_en && offs == `SP_GPIO_INTEN) begin
                inten_q <= pwdata_i;
            end
            // new edges win over the read clear
            intstat_q <= (rd_stat ? '0 : intstat_q) | rise;
            irq_q     <= |rise;
        end
    end

    always_comb begin
        prdata_o  = '0;
        pslverr_o = 1'b0;
        case (offs)
            `SP_GPIO_DIR:     prdata_o = dir_q;
            `SP_GPIO_IN:      prdata_o = sync2_q;
            `SP_GPIO_OUT:     prdata_o = out_q;
            `SP_GPIO_INTEN:   prdata_o = inten_q;
            `SP_GPIO_INTSTAT: prdata_o = intstat_q;
            default:          pslverr_o = psel_i;
        endcase
    end

    assign gpio_dir_o = dir_q;
    assign gpio_out_o = out_q;
    assign gpio_irq_o = irq_q;

endmodule

`default_nettype wire

/* logic/event_mask_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_periph_consts.svh"

module event_mask_regs (
    input  logic                      clk_i,
    input  logic                      arst_n_i,

    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  soc_periph_pkg::apb_addr_t paddr_i,
    input  soc_periph_pkg::apb_data_t pwdata_i,
    output soc_periph_pkg::apb_data_t prdata_o,
    output logic                      pslverr_o,

    output soc_periph_pkg::evt_vec_t  evt_mask_o,
    output logic [7:0]                sw_evt_o,

    input  logic                      evt_err_i,
    input  soc_periph_pkg::evt_id_t   err_id_i
);

    import soc_periph_pkg::*;

    localparam int PAD_W = `SP_APB_DW - `SP_EVT_NUM;

    evt_vec_t    mask_q;
    evt_vec_t    err_q;
    evt_vec_t    err_set;
    logic [7:0]  sw_q;
    logic [11:0] offs;
    logic        wr_en;
    logic        rd_err;

    assign offs   = paddr_i[11:0];
    assign wr_en  = psel_i & penable_i & pwrite_i;
    assign rd_err = psel_i & penable_i & ~pwrite_i & (offs == `SP_EVT_ERR);

    // one hot of the dropped id
    always_comb begin
        err_set = '0;
        for (int i = 0; i < `SP_EVT_NUM; i++) begin
            err_set[i] = evt_err_i && (err_id_i == evt_id_t'(i));
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mask_q <= '0;
            sw_q   <= '0;
            err_q  <= '0;
        end else begin
            if (wr_en && offs == `SP_EVT_MASK) begin
                mask_q <= pwdata_i[`SP_EVT_NUM-1:0];
            end
            sw_q  <= (wr_en && offs == `SP_EVT_SW) ? pwdata_i[7:0] : 8'h00; // single pulse
            err_q <= (rd_err ? '0 : err_q) | err_set;                      // clear on read
        end
    end

    ////////////////////////////////////////////////////////////
    // register readback
    ////////////////////////////////////////////////////////////
    always_comb begin
        prdata_o  = '0;
        pslverr_o = 1'b0;
        case (offs)
            `SP_EVT_MASK: prdata_o = {{PAD_W{1'b0}}, mask_q};
            `SP_EVT_SW:   prdata_o = '0;               // write only trigger
            `SP_EVT_ERR:  prdata_o = {{PAD_W{1'b0}}, err_q};
            default:      pslverr_o = psel_i;
        endcase
    end

    assign evt_mask_o = mask_q;
    assign sw_evt_o   = sw_q;

endmodule

`default_nettype wire

/* logic/soc_event_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_periph_consts.svh"

module soc_event_gen (
    input  logic                     clk_i,
    input  logic                     arst_n_i,

    input  logic                     slow_clk_i,
    input  logic                     gpio_irq_i,
    input  logic [7:0]               sw_evt_i,
    input  soc_periph_pkg::evt_vec_t evt_mask_i,

    output logic                     ref_evt_o,
    output logic                     evt_err_o,
    output soc_periph_pkg::evt_id_t  err_id_o,

    output logic                     fc_event_valid_o,
    output soc_periph_pkg::evt_id_t  fc_event_data_o,
    input  logic                     fc_event_ready_i
);

    import soc_periph_pkg::*;

    localparam int DEPTH = `SP_EVT_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    logic             ref_s1_q;
    logic             ref_s2_q;
    logic             ref_s3_q;
    logic             ref_rise_q;
    logic             ref_fall_q;
    evt_vec_t         evt_in;
    evt_vec_t         evt_act;
    evt_vec_t         pend_q;
    evt_vec_t         low_oh;
    evt_vec_t         clear_oh;
    evt_vec_t         drop;
    evt_id_t          grant_id;
    logic             push;
    logic             pop;
    logic             fifo_full;
    logic             err_q;
    evt_id_t          err_id_q;
    evt_id_t          fifo_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   cnt_q;

    function automatic evt_id_t lowest_id(input evt_vec_t vec);
        evt_id_t id;
        id = '0;
        for (int i = `SP_EVT_NUM - 1; i >= 0; i--) begin
            if (vec[i]) begin
                id = evt_id_t'(i);
            end
        end
        return id;
    endfunction

    ////////////////////////////////////////////////////////////
    // reference clock sampled as data
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ref_s1_q   <= 1'b0;
            ref_s2_q   <= 1'b0;
            ref_s3_q   <= 1'b0;
            ref_rise_q <= 1'b0;
            ref_fall_q <= 1'b0;
        end else begin
            ref_s1_q   <= slow_clk_i;
            ref_s2_q   <= ref_s1_q;
            ref_s3_q   <= ref_s2_q;
            ref_rise_q <= ref_s2_q & ~ref_s3_q;
            ref_fall_q <= ~ref_s2_q & ref_s3_q;
        end
    end

    assign ref_evt_o = ref_rise_q | ref_fall_q;

    always_comb begin
        evt_in = '0;
        evt_in[`SP_EVT_ID_GPIO]      = gpio_irq_i;
        evt_in[`SP_EVT_ID_REF_RISE]  = ref_rise_q;
        evt_in[`SP_EVT_ID_REF_FALL]  = ref_fall_q;
        evt_in[`SP_EVT_ID_SW0 +: 8]  = sw_evt_i;
    end

    assign evt_act = evt_in & evt_mask_i;          // masked lines vanish here

    ////////////////////////////////////////////////////////////
    // pending flags and lowest id arbiter
    ////////////////////////////////////////////////////////////
    assign low_oh    = pend_q & (~pend_q + 1'b1);  // lowest set bit only
    assign grant_id  = lowest_id(pend_q);
    assign fifo_full = (cnt_q == (PTR_W+1)'(DEPTH));
    assign push      = (|pend_q) & ~fifo_full;
    assign clear_oh  = push ? low_oh : '0;
    assign drop      = evt_act & pend_q & ~clear_oh; // flag still busy

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pend_q   <= '0;
            err_q    <= 1'b0;
            err_id_q <= '0;
        end else begin
            pend_q   <= (pend_q & ~clear_oh) | evt_act;
            err_q    <= |drop;
            err_id_q <= lowest_id(drop);
        end
    end

    assign evt_err_o = err_q;
    assign err_id_o  = err_id_q;

    ////////////////////////////////////////////////////////////
    // event fifo towards the fc
    ////////////////////////////////////////////////////////////
    assign pop = fc_event_valid_o & fc_event_ready_i;

    always_ff @(posedge clk_i) begin
        if (push) begin
            fifo_mem[wr_ptr_q] <= grant_id;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    assign fc_event_valid_o = (cnt_q != '0);
    assign fc_event_data_o  = fifo_mem[rd_ptr_q];  // held until popped

endmodule

`default_nettype wire

/* logic/soc_peripherals.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_periph_consts.svh"

module soc_peripherals (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      slow_clk_i,

    input  soc_periph_pkg::apb_addr_t paddr_i,
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  soc_periph_pkg::apb_data_t pwdata_i,
    output soc_periph_pkg::apb_data_t prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,

    input  soc_periph_pkg::gpio_vec_t gpio_in_i,
    output soc_periph_pkg::gpio_vec_t gpio_out_o,
    output soc_periph_pkg::gpio_vec_t gpio_dir_o,

    output logic [31:0]               fc_events_o,

    output logic                      fc_event_valid_o,
    output soc_periph_pkg::evt_id_t   fc_event_data_o,
    input  logic                      fc_event_ready_i
);

    import soc_periph_pkg::*;

    logic       gpio_psel;
    logic       evt_psel;
    apb_data_t  gpio_prdata;
    apb_data_t  evt_prdata;
    logic       gpio_pslverr;
    logic       evt_pslverr;
    logic       gpio_irq;
    logic       ref_evt;
    logic       evt_err;
    evt_id_t    err_id;
    evt_vec_t   evt_mask;
    logic [7:0] sw_evt;

    // fixed fc event lines, unused bits stay low
    always_comb begin
        fc_events_o                 = '0;
        fc_events_o[`SP_FC_BIT_REF]  = ref_evt;
        fc_events_o[`SP_FC_BIT_GPIO] = gpio_irq;
        fc_events_o[`SP_FC_BIT_ERR]  = evt_err;
    end

    periph_apb_decode i_decode (
        .paddr_i        ( paddr_i      ),
        .psel_i         ( psel_i       ),
        .gpio_psel_o    ( gpio_psel    ),
        .evt_psel_o     ( evt_psel     ),
        .gpio_prdata_i  ( gpio_prdata  ),
        .gpio_pslverr_i ( gpio_pslverr ),
        .evt_prdata_i   ( evt_prdata   ),
        .evt_pslverr_i  ( evt_pslverr  ),
        .prdata_o       ( prdata_o     ),
        .pready_o       ( pready_o     ),
        .pslverr_o      ( pslverr_o    )
    );

    apb_gpio i_gpio (
        .clk_i      ( clk_i        ),
        .arst_n_i   ( arst_n_i     ),
        .psel_i     ( gpio_psel    ),
        .penable_i  ( penable_i    ),
        .pwrite_i   ( pwrite_i     ),
        .paddr_i    ( paddr_i      ),
        .pwdata_i   ( pwdata_i     ),
        .prdata_o   ( gpio_prdata  ),
        .pslverr_o  ( gpio_pslverr ),
        .gpio_in_i  ( gpio_in_i    ),
        .gpio_out_o ( gpio_out_o   ),
        .gpio_dir_o ( gpio_dir_o   ),
        .gpio_irq_o ( gpio_irq     )
    );

    event_mask_regs i_evt_regs (
        .clk_i      ( clk_i       ),
        .arst_n_i   ( arst_n_i    ),
        .psel_i     ( evt_psel    ),
        .penable_i  ( penable_i   ),
        .pwrite_i   ( pwrite_i    ),
        .paddr_i    ( paddr_i     ),
        .pwdata_i   ( pwdata_i    ),
        .prdata_o   ( evt_prdata  ),
        .pslverr_o  ( evt_pslverr ),
        .evt_mask_o ( evt_mask    ),
        .sw_evt_o   ( sw_evt      ),
        .evt_err_i  ( evt_err     ),
        .err_id_i   ( err_id      )
    );

    soc_event_gen i_evt_gen (
        .clk_i            ( clk_i            ),
        .arst_n_i         ( arst_n_i         ),
        .slow_clk_i       ( slow_clk_i       ),
        .gpio_irq_i       ( gpio_irq         ),
        .sw_evt_i         ( sw_evt           ),
        .evt_mask_i       ( evt_mask         ),
        .ref_evt_o        ( ref_evt          ),
        .evt_err_o        ( evt_err          ),
        .err_id_o         ( err_id           ),
        .fc_event_valid_o ( fc_event_valid_o ),
        .fc_event_data_o  ( fc_event_data_o  ),
        .fc_event_ready_i ( fc_event_ready_i )
    );

endmodule

`default_nettype wire

/* tests/soc_peripherals_chk.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_periph_consts.svh"

module soc_peripherals_chk (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic        pready_i,
    input  logic        fc_valid_i,
    input  logic [7:0]  fc_data_i,
    input  logic        fc_ready_i,
    input  logic [31:0] fc_events_i
);

    // a stalled event keeps its id until the fc takes it
    a_data_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (fc_valid_i && !fc_ready_i) |=> (fc_valid_i && $stable(fc_data_i)))
        else $error("fc event id changed or dropped while stalled");

    a_pready_high: assert property (@(posedge clk_i) pready_i)
        else $error("pready_o went low");

    a_err_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        fc_events_i[`SP_FC_BIT_ERR] |=> !fc_events_i[`SP_FC_BIT_ERR])
        else $error("event error pulse longer than one cycle");

    a_quiet_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !fc_valid_i)
        else $error("fc event presented during reset");

endmodule

bind soc_peripherals soc_peripherals_chk i_chk (
    .clk_i       ( clk_i            ),
    .arst_n_i    ( arst_n_i         ),
    .pready_i    ( pready_o         ),
    .fc_valid_i  ( fc_event_valid_o ),
    .fc_data_i   ( fc_event_data_o  ),
    .fc_ready_i  ( fc_event_ready_i ),
    .fc_events_i ( fc_events_o      )
);

`default_nettype wire

/* tests/tb_soc_peripherals.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_periph_consts.svh"

module tb_soc_peripherals;

    localparam int          DRIVE_DLY      = 1;
    localparam int          TEST_CYCLES    = 1000;            // summed budget of all tests
    localparam int          TIMEOUT_CYCLES = 2 * TEST_CYCLES;
    localparam logic [15:0] LFSR_SEED      = 16'd55;

    logic        clk;
    logic        arst_n;
    logic        slow_clk;
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [31:0] gpio_in;
    logic [31:0] gpio_out;
    logic [31:0] gpio_dir;
    logic [31:0] fc_events;
    logic        fc_valid;
    logic [7:0]  fc_data;
    logic        fc_ready;

    logic [15:0] lfsr_state = LFSR_SEED;
    logic [7:0]  evt_q[$];                                    // ids taken by the fc
    int          pulse_cnt[32];
    int          checks = 0;
    int          errors = 0;

    soc_peripherals i_dut (
        .clk_i            ( clk       ),
        .arst_n_i         ( arst_n    ),
        .slow_clk_i       ( slow_clk  ),
        .paddr_i          ( paddr     ),
        .psel_i           ( psel      ),
        .penable_i        ( penable   ),
        .pwrite_i         ( pwrite    ),
        .pwdata_i         ( pwdata    ),
        .prdata_o         ( prdata    ),
        .pready_o         ( pready    ),
        .pslverr_o        ( pslverr   ),
        .gpio_in_i        ( gpio_in   ),
        .gpio_out_o       ( gpio_out  ),
        .gpio_dir_o       ( gpio_dir  ),
        .fc_events_o      ( fc_events ),
        .fc_event_valid_o ( fc_valid  ),
        .fc_event_data_o  ( fc_data   ),
        .fc_event_ready_i ( fc_ready  )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (arst_n) begin
            if (fc_valid && fc_ready) begin
                evt_q.push_back(fc_data);
            end
            for (int b = 0; b < 32; b++) begin
                if (fc_events[b]) begin
                    pulse_cnt[b]++;
                end
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////
    function automatic logic lfsr_bit();
        logic out;
        logic fb;
        out        = lfsr_state[15];
        fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w = {w[30:0], lfsr_bit()};
        end
        return w;
    endfunction

    function automatic logic [31:0] reg_addr(input logic [3:0] slv, input logic [11:0] offs);
        return {16'h0000, slv, offs};
    endfunction

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s got 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #DRIVE_DLY;
    endtask

    // all bus tasks start and end just after a rising edge
    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
                             output logic err);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        idle(1);
        penable = 1'b1;
        @(negedge clk);
        err = pslverr;
        check_eq("pready on write", 32'(pready), 32'h1);
        idle(1);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data,
                            output logic err);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        idle(1);
        penable = 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        check_eq("pready on read", 32'(pready), 32'h1);
        idle(1);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
        logic err;
        apb_write(addr, data, err);
        check_eq($sformatf("pslverr on write 0x%08h", addr), 32'(err), 32'h0);
    endtask

    task automatic reg_check(input logic [31:0] addr, input logic [31:0] exp, input string what);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        check_eq(what, data, exp);
        check_eq({what, " pslverr"}, 32'(err), 32'h0);
    endtask

    task automatic wait_events(input int base, input int n, input int limit, input string what);
        int cycles;
        cycles = 0;
        while (evt_q.size() - base < n && cycles < limit) begin
            idle(1);
            cycles++;
        end
        if (evt_q.size() - base < n) begin
            errors++;
            $display("%s: only %0d of %0d events arrived within %0d cycles",
                     what, evt_q.size() - base, n, limit);
        end
    endtask

    task automatic wait_pulse(input int bit_idx, input int base, input int limit,
                              input string what);
        int cycles;
        cycles = 0;
        while (pulse_cnt[bit_idx] == base && cycles < limit) begin
            idle(1);
            cycles++;
        end
        if (pulse_cnt[bit_idx] == base) begin
            errors++;
            $display("%s: no pulse on fc_events_o[%0d] within %0d cycles", what, bit_idx, limit);
        end
    endtask

    // software bit i maps to id SW0 + i and the lowest id leaves first
    task automatic check_sw_events(input int base, input logic [7:0] sw_bits);
        int idx;
        idx = base;
        check_eq("sw event count", 32'(evt_q.size() - base), 32'($countones(sw_bits)));
        for (int i = 0; i < 8; i++) begin
            if (sw_bits[i] && idx < evt_q.size()) begin
                check_eq($sformatf("sw event %0d id", idx - base), 32'(evt_q[idx]),
                         32'(`SP_EVT_ID_SW0 + i));
                idx++;
            end
        end
    endtask

    task automatic check_unmapped(input logic [31:0] addr);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        check_eq($sformatf("unmapped read 0x%08h pslverr", addr), 32'(err), 32'h1);
        check_eq($sformatf("unmapped read 0x%08h data", addr), data, 32'h0);
        apb_write(addr, 32'hFFFF_FFFF, err);
        check_eq($sformatf("unmapped write 0x%08h pslverr", addr), 32'(err), 32'h1);
    endtask

    task automatic check_idle_fc_bits();
        for (int b = 0; b < 32; b++) begin
            if (b != `SP_FC_BIT_REF && b != `SP_FC_BIT_GPIO && b != `SP_FC_BIT_ERR) begin
                check_eq($sformatf("pulses on unused fc_events_o[%0d]", b),
                         32'(pulse_cnt[b]), 32'h0);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////
    task automatic gpio_regs_rw();
        logic [31:0] dir_val;
        logic [31:0] out_val;
        check_eq("valid after reset", 32'(fc_valid), 32'h0);
        check_eq("fc_events after reset", fc_events, 32'h0);
        check_eq("gpio_dir after reset", gpio_dir, 32'h0);
        check_eq("gpio_out after reset", gpio_out, 32'h0);
        reg_check(reg_addr(`SP_SLV_EVT, `SP_EVT_MASK), 32'h0, "MASK after reset");
        reg_check(reg_addr(`SP_SLV_GPIO, `SP_GPIO_INTEN), 32'h0, "INTEN after reset");
        dir_val = rand_bits(32);
        out_val = rand_bits(32);
        reg_write(reg_addr(`SP_SLV_GPIO, `SP_GPIO_DIR), dir_val);
        reg_write(reg_addr(`SP_SLV_GPIO, `SP_GPIO_OUT), out_val);
        check_eq("gpio_dir pins", gpio_dir, dir_val);
        check_eq("gpio_out pins", gpio_out, out_val);
        reg_check(reg_addr(`SP_SLV_GPIO, `SP_GPIO_DIR), dir_val, "DIR readback");
        reg_check(reg_addr(`SP_SLV_GPIO, `SP_GPIO_OUT), out_val, "OUT readback");
    endtask

    task automatic gpio_input_irq();
        logic [31:0] in_val;
        logic [31:0] r;
        logic [4:0]  pin;
        int          ebase;
        int          pbase;
        fc_ready = 1'b1;                                      // fc takes the gpio event
        reg_write(reg_addr(`SP_SLV_EVT, `SP_EVT_MASK), 32'h1 << `SP_EVT_ID_GPIO);
        in_val  = rand_bits(32);
        gpio_in = in_val;
        idle(4);                                              // through the synchronizer
        reg_check(reg_addr(`SP_SLV_GPIO, `SP_GPIO_IN), in_val, "IN register");
        r            = rand_bits(5);
        pin          = r[4:0];
        gpio_in[pin] = 1'b0;
        idle(4);
        reg_write(reg_addr(`SP_SLV_GPIO, `SP_GPIO_INTEN), 32'h1 << pin);
        ebase        = evt_q.size();
        pbase        = pulse_cnt[`SP_FC_BIT_GPIO];
        gpio_in[pin] = 1'b1;
        wait_pulse(`SP_FC_BIT_GPIO, pbase, 6, "gpio interrupt");
        wait_events(ebase, 1, 10, "gpio event");
        idle(3);
        check_eq("gpio event count", 32'(evt_q.size() - ebase), 32'h1);
        if (evt_q.size() > ebase) begin
            check_eq("gpio event id", 32'(evt_q[ebase]), 32'(`SP_EVT_ID_GPIO));
        end
        reg_check(reg_addr(`SP_SLV_GPIO, `SP_GPIO_INTSTAT), 32'h1 << pin, "INTSTAT");
        reg_check(reg_addr(`SP_SLV_GPIO, `SP_GPIO_INTSTAT), 32'h0, "INTSTAT after clear");
        reg_write(reg_addr(`SP_SLV_GPIO, `SP_GPIO_INTEN), 32'h0);
    endtask

    task automatic sw_event_order();
        int ebase;
        reg_write(reg_addr(`SP_SLV_EVT, `SP_EVT_MASK), 32'h0000_FF00);
        fc_ready = 1'b1;
        ebase    = evt_q.size();
        reg_write(reg_addr(`SP_SLV_EVT, `SP_EVT_SW), 32'h0000_00A5);
        wait_events(ebase, 4, 20, "sw events");
        idle(5);                                              // catch any duplicate
        check_sw_events(ebase, 8'hA5);
    endtask

    task automatic fifo_backpressure();
        int ebase;
        int pbase;
        fc_ready = 1'b0;
        ebase    = evt_q.size();
        pbase    = pulse_cnt[`SP_FC_BIT_ERR];
        reg_write(reg_addr(`SP_SLV_EVT, `SP_EVT_SW), 32'h0000_00FF);
        idle(8);
        check_eq("valid while stalled", 32'(fc_valid), 32'h1);
        check_eq("head id while stalled", 32'(fc_data), 32'(`SP_EVT_ID_SW0));
        check_eq("error before overflow", 32'(pulse_cnt[`SP_FC_BIT_ERR] - pbase), 32'h0);
        // id 12 is still pending, so this one is lost
        reg_write(reg_addr(`SP_SLV_EVT, `SP_EVT_SW), 32'h0000_0010);
        wait_pulse(`SP_FC_BIT_ERR, pbase, 6, "overflow error");
        reg_check(reg_addr(`SP_SLV_EVT, `SP_EVT_ERR), 32'h1 << (`SP_EVT_ID_SW0 + 4), "ERR");
        reg_check(reg_addr(`SP_SLV_EVT, `SP_EVT_ERR), 32'h0, "ERR after clear");
        check_eq("error pulse count", 32'(pulse_cnt[`SP_FC_BIT_ERR] - pbase), 32'h1);
        fc_ready = 1'b1;
        wait_events(ebase, 8, 30, "drain after stall");
        idle(5);
        check_sw_events(ebase, 8'hFF);
        check_eq("valid after drain", 32'(fc_valid), 32'h0);
    endtask

    task automatic mask_and_ref_edges();
        int ebase;
        int pbase;
        reg_write(reg_addr(`SP_SLV_EVT, `SP_EVT_MASK),
                  (32'h1 << `SP_EVT_ID_REF_RISE) | (32'h1 << `SP_EVT_ID_REF_FALL));
        ebase = evt_q.size();
        reg_write(reg_addr(`SP_SLV_EVT, `SP_EVT_SW), 32'h0000_0002);
        idle(10);
        check_eq("masked sw event", 32'(evt_q.size() - ebase), 32'h0);
        pbase = pulse_cnt[`SP_FC_BIT_REF];
        repeat (4) begin                                      // two slow clock periods
            slow_clk = ~slow_clk;
            idle(8);
        end
        wait_events(ebase, 4, 20, "reference edge events");
        idle(5);
        check_eq("ref edge pulses", 32'(pulse_cnt[`SP_FC_BIT_REF] - pbase), 32'h4);
        check_eq("ref event count", 32'(evt_q.size() - ebase), 32'h4);
        for (int k = 0; k < 4 && ebase + k < evt_q.size(); k++) begin
            check_eq($sformatf("ref event %0d id", k), 32'(evt_q[ebase + k]),
                     (k % 2 == 0) ? 32'(`SP_EVT_ID_REF_RISE) : 32'(`SP_EVT_ID_REF_FALL));
        end
        reg_write(reg_addr(`SP_SLV_EVT, `SP_EVT_MASK), 32'h0);
    endtask

    task automatic unmapped_access();
        check_unmapped(reg_addr(4'd3, 12'h000));
        check_unmapped(reg_addr(`SP_SLV_GPIO, 12'h014));
        check_unmapped(reg_addr(`SP_SLV_EVT, 12'h014));
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        arst_n   = 1'b0;
        slow_clk = 1'b0;
        paddr    = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        pwdata   = '0;
        gpio_in  = '0;
        fc_ready = 1'b0;
        idle(5);
        arst_n = 1'b1;
        idle(2);

        gpio_regs_rw();
        gpio_input_irq();
        sw_event_order();
        fifo_backpressure();
        mask_and_ref_edges();
        unmapped_access();
        check_idle_fc_bits();

        idle(2);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+logic
logic/soc_periph_pkg.sv
logic/periph_apb_decode.sv
logic/apb_gpio.sv
logic/event_mask_regs.sv
logic/soc_event_gen.sv
logic/soc_peripherals.sv
tests/soc_peripherals_chk.sv
tests/tb_soc_peripherals.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_soc_peripherals
FILELIST  := files.f

SIM       := obj_dir/V$(TOP)
SRCS      := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard logic/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir
